// ==== logic/hdc_consts.svh ====
`ifndef HDC_CONSTS_SVH
`define HDC_CONSTS_SVH

// datapath sizes
`define HDC_WORD_W          32
`define HDC_WORDS_PER_HV    2
`define HDC_DIM             (`HDC_WORD_W * `HDC_WORDS_PER_HV)
`define HDC_ITEM_AW         4
`define HDC_CNT_W           8
`define HDC_INSTR_W         16

// register map, byte offsets
`define HDC_REG_AW          12
`define HDC_REG_CTRL        12'h000
`define HDC_REG_ITEM_NUM    12'h004

// xorshift reload value
`define HDC_PRNG_SEED       32'h2545F491

`endif

// ==== logic/hdc_pkg.sv ====
`default_nettype none

`include "hdc_consts.svh"

package hdc_pkg;

    // one hypervector, one bit per dimension
    typedef logic [`HDC_DIM-1:0] hv_t;

    typedef logic [`HDC_ITEM_AW-1:0] item_addr_t;

    // bit 1 run, bit 0 gen, as in the CTRL register
    typedef struct packed {
        logic run;
        logic gen;
    } mode_t;

    // write port of the item memory
    typedef struct packed {
        logic       valid;
        item_addr_t addr;
        hv_t        data;
    } item_wr_t;

endpackage

`default_nettype wire

// ==== logic/hdc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_regs import hdc_pkg::*; (
    input  wire                       AXIS_ACLK,
    input  wire                       S_AXI_ARESETN,
    input  wire [`HDC_REG_AW-1:0]     S_AXI_AWADDR,
    input  wire                       S_AXI_AWVALID,
    output logic                      S_AXI_AWREADY,
    input  wire [`HDC_WORD_W-1:0]     S_AXI_WDATA,
    input  wire [`HDC_WORD_W/8-1:0]   S_AXI_WSTRB,
    input  wire                       S_AXI_WVALID,
    output logic                      S_AXI_WREADY,
    output logic [1:0]                S_AXI_BRESP,
    output logic                      S_AXI_BVALID,
    input  wire                       S_AXI_BREADY,
    input  wire [`HDC_REG_AW-1:0]     S_AXI_ARADDR,
    input  wire                       S_AXI_ARVALID,
    output logic                      S_AXI_ARREADY,
    output logic [`HDC_WORD_W-1:0]    S_AXI_RDATA,
    output logic [1:0]                S_AXI_RRESP,
    output logic                      S_AXI_RVALID,
    input  wire                       S_AXI_RREADY,
    input  wire                       gen_done,
    output mode_t                     mode,
    output logic [`HDC_ITEM_AW:0]     item_num
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_WRESP,
        ST_RDEC,
        ST_RRESP
    } state_t;

    state_t                     state;
    logic [`HDC_REG_AW-1:0]     wr_addr;
    logic [`HDC_REG_AW-1:0]     rd_addr;
    logic [`HDC_WORD_W-1:0]     wr_data;
    logic [`HDC_WORD_W/8-1:0]   wr_strb;
    // high on the first cycle of ST_WRESP only
    logic                       wr_fire;

    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_DATA);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_ADDR);
    // writes win in idle, so no AR handshake is lost beside them
    assign S_AXI_ARREADY = (state == ST_IDLE) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == ST_WRESP);
    assign S_AXI_RVALID  = (state == ST_RRESP);
    assign S_AXI_BRESP   = 2'b00;
    assign S_AXI_RRESP   = 2'b00;

    // -------------------------------------------------------------------------
    // channel state machine
    // -------------------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        wr_fire <= 1'b0;
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state   <= ST_WRESP;
                        wr_fire <= 1'b1;
                    end else if (S_AXI_AWVALID) begin
                        state <= ST_ADDR;
                    end else if (S_AXI_WVALID) begin
                        state <= ST_DATA;
                    end else if (S_AXI_ARVALID) begin
                        state <= ST_RDEC;
                    end
                end
                ST_ADDR: begin
                    if (S_AXI_WVALID) begin
                        state   <= ST_WRESP;
                        wr_fire <= 1'b1;
                    end
                end
                ST_DATA: begin
                    if (S_AXI_AWVALID) begin
                        state   <= ST_WRESP;
                        wr_fire <= 1'b1;
                    end
                end
                ST_WRESP: begin
                    if (S_AXI_BREADY) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RDEC: begin
                    state <= ST_RRESP;
                end
                ST_RRESP: begin
                    if (S_AXI_RREADY) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address, data and read word capture
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            wr_addr <= S_AXI_AWADDR;
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wr_data <= S_AXI_WDATA;
            wr_strb <= S_AXI_WSTRB;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            rd_addr <= S_AXI_ARADDR;
        end
        if (state == ST_RDEC) begin
            case (rd_addr)
                `HDC_REG_CTRL:     S_AXI_RDATA <= `HDC_WORD_W'(mode);
                `HDC_REG_ITEM_NUM: S_AXI_RDATA <= `HDC_WORD_W'(item_num);
                default:           S_AXI_RDATA <= '0;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // control registers
    // -------------------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            mode     <= '0;
            item_num <= '0;
        end else if (wr_fire) begin
            // both fields live in byte 0
            if (wr_strb[0]) begin
                case (wr_addr)
                    `HDC_REG_CTRL:     mode     <= wr_data[1:0];
                    `HDC_REG_ITEM_NUM: item_num <= wr_data[`HDC_ITEM_AW:0];
                    default:           ;
                endcase
            end
        end else if (gen_done) begin
            // generator finished its last item
            mode.gen <= 1'b0;
        end
    end

    // done only arrives while generating
    a_done_in_gen: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        gen_done |-> mode.gen);

endmodule

`default_nettype wire

// ==== logic/item_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module item_gen import hdc_pkg::*; (
    input  wire                     AXIS_ACLK,
    input  wire                     S_AXI_ARESETN,
    input  wire                     gen,
    input  wire [`HDC_ITEM_AW:0]    item_num,
    output item_wr_t                item_wr,
    output logic                    gen_done
);

    localparam int WORD_W    = `HDC_WORD_W;
    localparam int LAST_WORD = `HDC_WORDS_PER_HV - 1;
    localparam int IDX_W     = $clog2(`HDC_WORDS_PER_HV);

    logic [WORD_W-1:0]  prng;
    logic [WORD_W-1:0]  prng_nxt;
    logic [IDX_W-1:0]   word_idx;
    item_addr_t         item_addr;
    // full hypervector sits in hv_buf
    logic               wr_pend;
    hv_t                hv_buf;

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [WORD_W-1:0] xorshift(input logic [WORD_W-1:0] x);
        logic [WORD_W-1:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    assign prng_nxt = xorshift(prng);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            prng      <= `HDC_PRNG_SEED;
            word_idx  <= '0;
            item_addr <= '0;
            wr_pend   <= 1'b0;
        end else begin
            prng     <= prng_nxt;
            word_idx <= (word_idx == IDX_W'(LAST_WORD)) ? '0 : word_idx + 1'b1;
            wr_pend  <= (word_idx == IDX_W'(LAST_WORD));
            if (wr_pend) begin
                item_addr <= item_addr + 1'b1;
            end
        end
    end

    // word j lands at bit j*32
    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            hv_buf[word_idx*WORD_W +: WORD_W] <= prng_nxt;
        end
    end

    always_comb begin
        item_wr.valid = wr_pend && gen;
        item_wr.addr  = item_addr;
        item_wr.data  = hv_buf;
    end

    // counts above 16 stop at the last address
    assign gen_done = item_wr.valid
                      && ((({1'b0, item_addr} + 1'b1) >= item_num) || (item_addr == '1));

    // a zero state would lock the xorshift at zero
    a_prng_live: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        prng != '0);

endmodule

`default_nettype wire

// ==== logic/item_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module item_memory import hdc_pkg::*; (
    input  wire             AXIS_ACLK,
    input  wire item_wr_t   item_wr,
    input  wire item_addr_t rd_addr,
    output hv_t             rd_data
);

    localparam int DEPTH = 1 << `HDC_ITEM_AW;

    hv_t mem [DEPTH];

    always_ff @(posedge AXIS_ACLK) begin
        if (item_wr.valid) begin
            mem[item_wr.addr] <= item_wr.data;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge AXIS_ACLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/bundle_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module bundle_encoder import hdc_pkg::*; (
    input  wire                     AXIS_ACLK,
    input  wire                     S_AXI_ARESETN,
    input  wire                     run,
    input  wire [`HDC_INSTR_W-1:0]  S_AXIS_TDATA,
    input  wire                     S_AXIS_TVALID,
    input  wire                     S_AXIS_TLAST,
    output logic                    S_AXIS_TREADY,
    output item_addr_t              rd_addr,
    input  wire hv_t                rd_data,
    output hv_t                     M_AXIS_TDATA,
    output logic                    M_AXIS_TVALID,
    output logic                    M_AXIS_TLAST,
    input  wire                     M_AXIS_TREADY
);

    localparam int CNT_W = `HDC_CNT_W;
    localparam logic signed [CNT_W-1:0] CNT_MAX = CNT_W'(2 ** (CNT_W - 1) - 1);
    localparam logic signed [CNT_W-1:0] CNT_MIN = -CNT_MAX;
    localparam logic signed [CNT_W-1:0] CNT_ONE = CNT_W'(1);

    logic signed [CNT_W-1:0] cnt [`HDC_DIM];
    logic signed [CNT_W-1:0] cnt_nxt [`HDC_DIM];
    hv_t                     sign_nxt;
    // lookup in flight, memory data arrives next cycle
    logic                    lk_valid;
    logic                    lk_last;
    logic                    beat_in;
    logic                    beat_out;

    assign S_AXIS_TREADY = run && !lk_valid && !M_AXIS_TVALID;
    assign beat_in       = S_AXIS_TVALID && S_AXIS_TREADY;
    assign beat_out      = M_AXIS_TVALID && M_AXIS_TREADY;
    assign rd_addr       = S_AXIS_TDATA[`HDC_ITEM_AW-1:0];
    // every result is a single-beat packet
    assign M_AXIS_TLAST  = 1'b1;

    // -------------------------------------------------------------------------
    // saturating +1 / -1 per dimension
    // -------------------------------------------------------------------------
    always_comb begin
        for (int d = 0; d < `HDC_DIM; d++) begin
            if (rd_data[d]) begin
                cnt_nxt[d] = (cnt[d] == CNT_MAX) ? cnt[d] : cnt[d] + CNT_ONE;
            end else begin
                cnt_nxt[d] = (cnt[d] == CNT_MIN) ? cnt[d] : cnt[d] - CNT_ONE;
            end
            sign_nxt[d] = (cnt_nxt[d] > 0);
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        for (int d = 0; d < `HDC_DIM; d++) begin
            if (!S_AXI_ARESETN || !run || beat_out) begin
                cnt[d] <= '0;
            end else if (lk_valid) begin
                cnt[d] <= cnt_nxt[d];
            end
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !run) begin
            lk_valid <= 1'b0;
            lk_last  <= 1'b0;
        end else begin
            lk_valid <= beat_in;
            lk_last  <= beat_in && S_AXIS_TLAST;
        end
    end

    // -------------------------------------------------------------------------
    // output beat
    // -------------------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            M_AXIS_TVALID <= 1'b0;
        end else if (lk_valid && lk_last) begin
            M_AXIS_TVALID <= 1'b1;
        end else if (beat_out) begin
            M_AXIS_TVALID <= 1'b0;
        end
    end

    // signs taken from the counters after the last update
    always_ff @(posedge AXIS_ACLK) begin
        if (lk_valid && lk_last) begin
            M_AXIS_TDATA <= sign_nxt;
        end
    end

    a_tvalid_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        M_AXIS_TVALID && !M_AXIS_TREADY |=> M_AXIS_TVALID && $stable(M_AXIS_TDATA));

endmodule

`default_nettype wire

// ==== logic/hdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_top import hdc_pkg::*; (
    input  wire                       AXIS_ACLK,
    input  wire                       S_AXI_ARESETN,
    // AXI-Lite slave
    input  wire [`HDC_REG_AW-1:0]     S_AXI_AWADDR,
    input  wire                       S_AXI_AWVALID,
    output wire                       S_AXI_AWREADY,
    input  wire [`HDC_WORD_W-1:0]     S_AXI_WDATA,
    input  wire [`HDC_WORD_W/8-1:0]   S_AXI_WSTRB,
    input  wire                       S_AXI_WVALID,
    output wire                       S_AXI_WREADY,
    output wire [1:0]                 S_AXI_BRESP,
    output wire                       S_AXI_BVALID,
    input  wire                       S_AXI_BREADY,
    input  wire [`HDC_REG_AW-1:0]     S_AXI_ARADDR,
    input  wire                       S_AXI_ARVALID,
    output wire                       S_AXI_ARREADY,
    output wire [`HDC_WORD_W-1:0]     S_AXI_RDATA,
    output wire [1:0]                 S_AXI_RRESP,
    output wire                       S_AXI_RVALID,
    input  wire                       S_AXI_RREADY,
    // item address stream in
    input  wire [`HDC_INSTR_W-1:0]    S_AXIS_TDATA,
    input  wire                       S_AXIS_TVALID,
    input  wire                       S_AXIS_TLAST,
    output wire                       S_AXIS_TREADY,
    // bundled hypervector out
    output wire [`HDC_DIM-1:0]        M_AXIS_TDATA,
    output wire                       M_AXIS_TVALID,
    output wire [`HDC_DIM/8-1:0]      M_AXIS_TSTRB,
    output wire                       M_AXIS_TLAST,
    input  wire                       M_AXIS_TREADY
);

    wire mode_t                 mode;
    wire [`HDC_ITEM_AW:0]       item_num;
    wire                        gen_done;
    wire item_wr_t              item_wr;
    wire item_addr_t            rd_addr;
    wire hv_t                   rd_data;

    assign M_AXIS_TSTRB = '1;

    hdc_regs u_regs (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .S_AXI_AWADDR   (S_AXI_AWADDR),
        .S_AXI_AWVALID  (S_AXI_AWVALID),
        .S_AXI_AWREADY  (S_AXI_AWREADY),
        .S_AXI_WDATA    (S_AXI_WDATA),
        .S_AXI_WSTRB    (S_AXI_WSTRB),
        .S_AXI_WVALID   (S_AXI_WVALID),
        .S_AXI_WREADY   (S_AXI_WREADY),
        .S_AXI_BRESP    (S_AXI_BRESP),
        .S_AXI_BVALID   (S_AXI_BVALID),
        .S_AXI_BREADY   (S_AXI_BREADY),
        .S_AXI_ARADDR   (S_AXI_ARADDR),
        .S_AXI_ARVALID  (S_AXI_ARVALID),
        .S_AXI_ARREADY  (S_AXI_ARREADY),
        .S_AXI_RDATA    (S_AXI_RDATA),
        .S_AXI_RRESP    (S_AXI_RRESP),
        .S_AXI_RVALID   (S_AXI_RVALID),
        .S_AXI_RREADY   (S_AXI_RREADY),
        .gen_done       (gen_done),
        .mode           (mode),
        .item_num       (item_num)
    );

    // gen side
    item_gen u_gen (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .gen            (mode.gen),
        .item_num       (item_num),
        .item_wr        (item_wr),
        .gen_done       (gen_done)
    );

    item_memory u_mem (
        .AXIS_ACLK      (AXIS_ACLK),
        .item_wr        (item_wr),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data)
    );

    // run side
    bundle_encoder u_enc (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .run            (mode.run),
        .S_AXIS_TDATA   (S_AXIS_TDATA),
        .S_AXIS_TVALID  (S_AXIS_TVALID),
        .S_AXIS_TLAST   (S_AXIS_TLAST),
        .S_AXIS_TREADY  (S_AXIS_TREADY),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .M_AXIS_TDATA   (M_AXIS_TDATA),
        .M_AXIS_TVALID  (M_AXIS_TVALID),
        .M_AXIS_TLAST   (M_AXIS_TLAST),
        .M_AXIS_TREADY  (M_AXIS_TREADY)
    );

endmodule

`default_nettype wire

// ==== sim/tb_hdc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_consts.svh"

module tb_hdc import hdc_pkg::*; ();

    localparam int PAT_WORDS = 256;
    localparam int CNT_SAT   = 127;

    logic                       AXIS_ACLK;
    logic                       S_AXI_ARESETN;
    logic [`HDC_REG_AW-1:0]     awaddr;
    logic                       awvalid;
    wire                        awready;
    logic [`HDC_WORD_W-1:0]     wdata;
    logic [`HDC_WORD_W/8-1:0]   wstrb;
    logic                       wvalid;
    wire                        wready;
    wire  [1:0]                 bresp;
    wire                        bvalid;
    logic                       bready;
    logic [`HDC_REG_AW-1:0]     araddr;
    logic                       arvalid;
    wire                        arready;
    wire  [`HDC_WORD_W-1:0]     rdata;
    wire  [1:0]                 rresp;
    wire                        rvalid;
    logic                       rready;
    logic [`HDC_INSTR_W-1:0]    s_tdata;
    logic                       s_tvalid;
    logic                       s_tlast;
    wire                        s_tready;
    wire  [`HDC_DIM-1:0]        m_tdata;
    wire                        m_tvalid;
    wire  [`HDC_DIM/8-1:0]      m_tstrb;
    wire                        m_tlast;
    logic                       m_tready;

    // one pattern is four words: opcode, a, b, c
    logic [31:0]    pat [PAT_WORDS];
    hv_t            model_item [1 << `HDC_ITEM_AW];
    item_addr_t     pkt [$];
    logic [31:0]    rng;
    int             cycles = 0;
    int             limit = 0;

    hdc_top dut_i (
        .AXIS_ACLK      (AXIS_ACLK),
        .S_AXI_ARESETN  (S_AXI_ARESETN),
        .S_AXI_AWADDR   (awaddr),
        .S_AXI_AWVALID  (awvalid),
        .S_AXI_AWREADY  (awready),
        .S_AXI_WDATA    (wdata),
        .S_AXI_WSTRB    (wstrb),
        .S_AXI_WVALID   (wvalid),
        .S_AXI_WREADY   (wready),
        .S_AXI_BRESP    (bresp),
        .S_AXI_BVALID   (bvalid),
        .S_AXI_BREADY   (bready),
        .S_AXI_ARADDR   (araddr),
        .S_AXI_ARVALID  (arvalid),
        .S_AXI_ARREADY  (arready),
        .S_AXI_RDATA    (rdata),
        .S_AXI_RRESP    (rresp),
        .S_AXI_RVALID   (rvalid),
        .S_AXI_RREADY   (rready),
        .S_AXIS_TDATA   (s_tdata),
        .S_AXIS_TVALID  (s_tvalid),
        .S_AXIS_TLAST   (s_tlast),
        .S_AXIS_TREADY  (s_tready),
        .M_AXIS_TDATA   (m_tdata),
        .M_AXIS_TVALID  (m_tvalid),
        .M_AXIS_TSTRB   (m_tstrb),
        .M_AXIS_TLAST   (m_tlast),
        .M_AXIS_TREADY  (m_tready)
    );

    initial begin
        AXIS_ACLK = 1'b0;
        forever #5 AXIS_ACLK = ~AXIS_ACLK;
    end

    always @(posedge AXIS_ACLK) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout, the run did not finish within %0d cycles", limit);
            $display("ERRORS FOUND");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------------------
    // models and helpers
    // ------------------------------------------------------------------------

    // xorshift32 with shifts 13 left, 17 right, 5 left
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task axil_write(input logic [`HDC_REG_AW-1:0] addr, input logic [31:0] data);
        logic aw_hs;
        logic w_hs;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = '1;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(negedge AXIS_ACLK);
            if (aw_hs) awvalid = 1'b0;
            if (w_hs) wvalid = 1'b0;
        end
        bready = 1'b1;
        while (!bvalid) @(negedge AXIS_ACLK);
        check_value("S_AXI_BRESP", 64'(bresp), 64'h0);
        @(negedge AXIS_ACLK);
        bready = 1'b0;
    endtask

    task axil_read(input logic [`HDC_REG_AW-1:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge AXIS_ACLK);
        data = rdata;
        check_value("S_AXI_RRESP", 64'(rresp), 64'h0);
        @(negedge AXIS_ACLK);
        rready = 1'b0;
    endtask

    task send_beat(input item_addr_t addr, input logic last);
        s_tdata  = `HDC_INSTR_W'(addr);
        s_tvalid = 1'b1;
        s_tlast  = last;
        while (!s_tready) @(negedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // sign of the saturated per-dimension sum over pkt
    task bundle_model(output hv_t result);
        int cnt [`HDC_DIM];
        foreach (cnt[d]) cnt[d] = 0;
        foreach (pkt[i]) begin
            for (int d = 0; d < `HDC_DIM; d++) begin
                if (model_item[pkt[i]][d]) begin
                    if (cnt[d] < CNT_SAT) cnt[d]++;
                end else if (cnt[d] > -CNT_SAT) begin
                    cnt[d]--;
                end
            end
        end
        for (int d = 0; d < `HDC_DIM; d++) begin
            result[d] = (cnt[d] > 0);
        end
    endtask

    task encode_packet(input logic stall);
        hv_t         exp_hv;
        logic        ready;
        logic [31:0] r;
        bundle_model(exp_hv);
        foreach (pkt[i]) send_beat(pkt[i], i == pkt.size() - 1);
        while (!m_tvalid) @(negedge AXIS_ACLK);
        ready = 1'b0;
        while (!ready) begin
            check_value("M_AXIS_TVALID", 64'(m_tvalid), 64'h1);
            check_value("M_AXIS_TDATA", 64'(m_tdata), 64'(exp_hv));
            check_value("M_AXIS_TLAST", 64'(m_tlast), 64'h1);
            check_value("M_AXIS_TSTRB", 64'(m_tstrb), 64'hff);
            check_value("S_AXIS_TREADY", 64'(s_tready), 64'h0);
            r        = next_rand();
            ready    = stall ? r[0] : 1'b1;
            m_tready = ready;
            @(negedge AXIS_ACLK);
        end
        m_tready = 1'b0;
        pkt.delete();
    endtask

    // ------------------------------------------------------------------------
    // pattern sequencer
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] op;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] op_c;
        logic [31:0] rd;
        logic [31:0] x;
        int          beats;
        int          len;
        int          pc;

        S_AXI_ARESETN = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        s_tdata  = '0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        m_tready = 1'b0;
        rng      = 32'd72;

        // item k holds outputs 2k+1 (low word) and 2k+2 after the seed
        x = `HDC_PRNG_SEED;
        foreach (model_item[k]) begin
            x = xorshift32(x);
            model_item[k][31:0] = x;
            x = xorshift32(x);
            model_item[k][63:32] = x;
        end

        foreach (pat[i]) pat[i] = '0;
        $readmemh("sim/hdc_patterns.txt", pat);

        beats = 0;
        for (pc = 0; pc < PAT_WORDS / 4 && pat[4*pc] != 32'h0; pc++) begin
            case (pat[4*pc])
                32'h4:   beats += int'(pat[4*pc+2]);
                32'h5:   beats += int'(pat[4*pc+1]) * int'(pat[4*pc+2]);
                32'h6:   beats += 2 * int'(pat[4*pc+3]);
                32'h8:   beats += int'(pat[4*pc+1]);
                default: beats += 1;
            endcase
        end
        limit = 200 + 20 * beats;

        repeat (2) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;
        @(negedge AXIS_ACLK);

        for (pc = 0; pc < PAT_WORDS / 4 && pat[4*pc] != 32'h0; pc++) begin
            op   = pat[4*pc];
            op_a = pat[4*pc+1];
            op_b = pat[4*pc+2];
            op_c = pat[4*pc+3];
            case (op)
                32'h1: begin
                    axil_write(`HDC_REG_AW'(op_a), op_b);
                    axil_read(`HDC_REG_AW'(op_a), rd);
                    check_value("S_AXI_RDATA", 64'(rd), 64'(op_c));
                end
                32'h2: begin
                    axil_read(`HDC_REG_AW'(op_a), rd);
                    check_value("S_AXI_RDATA", 64'(rd), 64'(op_c));
                end
                32'h3: begin
                    axil_write(`HDC_REG_ITEM_NUM, op_a);
                    axil_write(`HDC_REG_CTRL, op_b);
                    rd = op_b;
                    // gen clears itself once the last item is written
                    while (rd[0]) axil_read(`HDC_REG_CTRL, rd);
                    check_value("S_AXI_RDATA", 64'(rd), 64'(op_c));
                end
                32'h4: begin
                    for (int k = 0; k < int'(op_b); k++) begin
                        pkt.push_back(`HDC_ITEM_AW'(op_a + 32'(k)));
                        encode_packet(1'b0);
                    end
                end
                32'h5: begin
                    for (int n = 0; n < int'(op_a); n++) begin
                        rd  = next_rand();
                        len = 2 + int'(rd % (op_b - 32'd1));
                        repeat (len) begin
                            rd = next_rand();
                            pkt.push_back(rd[`HDC_ITEM_AW-1:0]);
                        end
                        encode_packet(op_c[0]);
                    end
                end
                32'h6: begin
                    repeat (int'(op_c)) pkt.push_back(`HDC_ITEM_AW'(op_a));
                    repeat (int'(op_c) - 1) pkt.push_back(`HDC_ITEM_AW'(op_b));
                    encode_packet(1'b0);
                end
                32'h7: begin
                    check_value("S_AXIS_TREADY", 64'(s_tready), 64'(op_a));
                end
                32'h8: begin
                    // packet left open, no TLAST
                    repeat (int'(op_a)) begin
                        rd = next_rand();
                        send_beat(rd[`HDC_ITEM_AW-1:0], 1'b0);
                    end
                end
                default: begin
                    $display("unknown opcode %0h in pattern line %0d", op, pc);
                    $display("ERRORS FOUND");
                    $fatal(1, "bad pattern file");
                end
            endcase
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/hdc_patterns.txt ====
// op a b c, all hex. 1 write a=offset b=data c=readback, 2 read a=offset c=expected,
// 3 gen a=count b=ctrl c=ctrl after, 4 single beats a=first b=count, 5 random a=packets
// b=max length c=stall, 6 saturate a b c=count, 7 S_AXIS_TREADY=a, 8 open beats a, 0 end
1 000 00000002 00000002
1 004 0000000b 0000000b
1 004 ffffffff 0000001f
2 008 00000000 00000000
2 ffc 00000000 00000000
3 010 00000003 00000002
2 004 00000000 00000010
4 000 00000010 00000000
5 008 00000009 00000000
5 008 00000009 00000001
6 003 0000000c 00000082
8 003 00000000 00000000
1 000 00000000 00000000
7 000 00000000 00000000
1 000 00000002 00000002
4 005 00000001 00000000
0 000 00000000 00000000

// ==== filelist.f ====
+incdir+logic
logic/hdc_pkg.sv
logic/hdc_regs.sv
logic/item_gen.sv
logic/item_memory.sv
logic/bundle_encoder.sv
logic/hdc_top.sv
sim/tb_hdc.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_hdc
FILELIST    ?= filelist.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --assert
EXTRA_FLAGS ?=

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
